// File: src.f
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/control_unit.sv
logic/imm_extend.sv
logic/alu.sv
logic/reg_file.sv
logic/pc_unit.sv
logic/rv_core.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := rv_core_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_STORES  = 32;     // one sw per register right after reset
    localparam int RANDOM_INSTRS = 2000;
    localparam int N_TESTS       = RESET_STORES + RANDOM_INSTRS;
    localparam int TIMEOUT_NS    = (N_TESTS + 20) * CLK_PERIOD;
    localparam int SEED          = 32'h5f4b;

    // one generated instruction before encoding
    typedef struct packed {
        rv_isa_pkg::opcode_e  kind;
        logic [2:0]           f3;
        logic                 alt;      // sub instead of add
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::word_t    imm;
    } op_t;

    logic              clk = 1'b0;
    logic              rst_n;
    rv_isa_pkg::word_t instr;
    rv_isa_pkg::addr_t pc;
    rv_isa_pkg::addr_t mem_addr;
    rv_isa_pkg::word_t mem_wdata;
    logic              mem_we;
    rv_isa_pkg::word_t mem_rdata;

    rv_isa_pkg::word_t dmem [64];       // data memory the dut talks to
    rv_isa_pkg::word_t mem_m [64];      // model copy
    rv_isa_pkg::word_t regs_m [32];
    rv_isa_pkg::addr_t pc_m;
    op_t               cur;             // instruction of the current cycle
    string             test_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core i_dut
    (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .instr_i     (instr),
        .pc_o        (pc),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_we_o    (mem_we),
        .mem_rdata_i (mem_rdata)
    );

    assign mem_rdata = dmem[mem_addr[7:2]];    // same cycle read

    always @(posedge clk)
    begin
        if (mem_we)
            dmem[mem_addr[7:2]] <= mem_wdata;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pc(input rv_isa_pkg::addr_t exp);
        if (pc !== exp)
            abort_run($sformatf("Mismatch %s pc: expected %h actual %h", test_name, exp, pc));
    endtask

    // strobe first, then address and data of a real store
    task automatic check_store(input logic exp_we, input rv_isa_pkg::addr_t exp_addr,
                               input rv_isa_pkg::word_t exp_data);
        if (mem_we !== exp_we)
            abort_run($sformatf("Mismatch %s mem_we: expected %b actual %b",
                                test_name, exp_we, mem_we));
        else if (exp_we && mem_addr !== exp_addr)
            abort_run($sformatf("Mismatch %s store addr: expected %h actual %h",
                                test_name, exp_addr, mem_addr));
        else if (exp_we && mem_wdata !== exp_data)
            abort_run($sformatf("Mismatch %s store data: expected %h actual %h",
                                test_name, exp_data, mem_wdata));
    endtask

    task automatic check_load_addr(input rv_isa_pkg::addr_t exp);
        if (mem_addr !== exp)
            abort_run($sformatf("Mismatch %s load addr: expected %h actual %h",
                                test_name, exp, mem_addr));
    endtask

    function automatic logic [2:0] pick_alu_f3();
        case ($urandom_range(0, 4))
            0:       return rv_isa_pkg::ADD_SUB;
            1:       return rv_isa_pkg::SLL;
            2:       return rv_isa_pkg::XOR;
            3:       return rv_isa_pkg::OR;
            default: return rv_isa_pkg::AND;
        endcase
    endfunction

    // random legal op, memory and jalr based on x0
    function automatic op_t gen_op();
        op_t         op;
        logic [11:0] r12;
        int          off;
        op     = '0;
        op.rd  = rv_isa_pkg::reg_idx_t'($urandom_range(0, 31));
        op.rs1 = rv_isa_pkg::reg_idx_t'($urandom_range(0, 31));
        op.rs2 = rv_isa_pkg::reg_idx_t'($urandom_range(0, 31));
        r12    = 12'($urandom);
        case ($urandom_range(0, 9))
            0, 1, 2:
            begin
                op.kind = ($urandom_range(0, 2) == 0) ? rv_isa_pkg::OP_LOAD
                                                     : rv_isa_pkg::OP_STORE;
                op.f3   = 3'b010;                       // word access
                op.rs1  = '0;
                op.imm  = $urandom_range(0, 63) * 4;    // aligned, below 256
            end
            3, 4:
            begin
                op.kind = rv_isa_pkg::OP_REG;
                op.f3   = pick_alu_f3();
                op.alt  = (op.f3 == rv_isa_pkg::ADD_SUB) && ($urandom_range(0, 1) != 0);
            end
            5, 6:
            begin
                op.kind = rv_isa_pkg::OP_IMM;
                op.f3   = pick_alu_f3();
                if (op.f3 == rv_isa_pkg::SLL)
                    op.imm = $urandom_range(0, 31);     // shamt only, funct7 zero
                else
                    op.imm = {{20{r12[11]}}, r12};
            end
            7:
            begin
                op.kind = rv_isa_pkg::OP_BRANCH;
                op.f3   = 3'($urandom_range(0, 1));     // beq or bne
                off     = $urandom_range(0, 32);
                op.imm  = (off - 16) * 4;
                if ($urandom_range(0, 1) != 0)
                    op.rs2 = op.rs1;                    // force equal operands
            end
            8:
            begin
                op.kind = rv_isa_pkg::OP_JAL;
                off     = $urandom_range(0, 64);
                op.imm  = (off - 32) * 4;
            end
            default:
            begin
                op.kind = rv_isa_pkg::OP_JALR;
                op.rs1  = '0;
                op.imm  = $urandom_range(0, 511) * 4;   // absolute target
            end
        endcase
        return op;
    endfunction

    function automatic op_t reset_store(input int idx);
        op_t op;
        op      = '0;
        op.kind = rv_isa_pkg::OP_STORE;
        op.f3   = 3'b010;
        op.rs2  = rv_isa_pkg::reg_idx_t'(idx);
        op.imm  = idx * 4;      // one word per register
        return op;
    endfunction

    // instruction formats from the base isa
    function automatic rv_isa_pkg::word_t encode(input op_t op);
        case (op.kind)
            rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_JALR:
                return {op.imm[11:0], op.rs1, op.f3, op.rd, op.kind};
            rv_isa_pkg::OP_STORE:
                return {op.imm[11:5], op.rs2, op.rs1, op.f3, op.imm[4:0], op.kind};
            rv_isa_pkg::OP_REG:
                return {1'b0, op.alt, 5'b0, op.rs2, op.rs1, op.f3, op.rd, op.kind};
            rv_isa_pkg::OP_BRANCH:
                return {op.imm[12], op.imm[10:5], op.rs2, op.rs1, op.f3,
                        op.imm[4:1], op.imm[11], op.kind};
            rv_isa_pkg::OP_JAL:
                return {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd, op.kind};
            default:
                return rv_isa_pkg::NOP_WORD;
        endcase
    endfunction

    function automatic rv_isa_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                    input rv_isa_pkg::word_t a,
                                                    input rv_isa_pkg::word_t b);
        case (f3)
            rv_isa_pkg::ADD_SUB: return alt ? a - b : a + b;
            rv_isa_pkg::SLL:     return a << b[4:0];
            rv_isa_pkg::XOR:     return a ^ b;
            rv_isa_pkg::OR:      return a | b;
            default:             return a & b;
        endcase
    endfunction

    task automatic write_reg(input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t val);
        if (rd != '0)
            regs_m[rd] = val;   // x0 stays zero
    endtask

    // architectural step of the model, one per rising edge
    task automatic step_model();
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        rv_isa_pkg::addr_t ea;
        rv_isa_pkg::addr_t next_pc;
        a       = regs_m[cur.rs1];
        b       = regs_m[cur.rs2];
        ea      = a + cur.imm;
        next_pc = pc_m + 4;
        case (cur.kind)
            rv_isa_pkg::OP_LOAD:  write_reg(cur.rd, mem_m[ea[7:2]]);
            rv_isa_pkg::OP_STORE: mem_m[ea[7:2]] = b;
            rv_isa_pkg::OP_REG:   write_reg(cur.rd, alu_model(cur.f3, cur.alt, a, b));
            rv_isa_pkg::OP_IMM:   write_reg(cur.rd, alu_model(cur.f3, 1'b0, a, cur.imm));
            rv_isa_pkg::OP_BRANCH:
            begin
                if ((cur.f3 == rv_isa_pkg::BEQ) == (a == b))
                    next_pc = pc_m + cur.imm;           // taken
            end
            rv_isa_pkg::OP_JAL:
            begin
                write_reg(cur.rd, pc_m + 4);
                next_pc = pc_m + cur.imm;
            end
            rv_isa_pkg::OP_JALR:
            begin
                next_pc = ea & ~32'd1;                  // target before link write
                write_reg(cur.rd, pc_m + 4);
            end
            default:
            begin
                // generator emits nothing else
            end
        endcase
        pc_m = next_pc;
    endtask

    task automatic check_cycle(input int idx);
        rv_isa_pkg::addr_t   ea;
        rv_isa_pkg::opcode_e kind;
        kind = cur.kind;
        ea   = regs_m[cur.rs1] + cur.imm;
        if (idx < RESET_STORES)
            test_name = $sformatf("reset_store_%0d", idx);
        else
            test_name = $sformatf("%s_%0d", kind.name(), idx);
        check_pc(pc_m);
        check_store(kind == rv_isa_pkg::OP_STORE, ea, regs_m[cur.rs2]);
        if (kind == rv_isa_pkg::OP_LOAD)
            check_load_addr(ea);
    endtask

    initial
    begin
        void'($urandom(SEED));                  // seed once
        rst_n    = 1'b0;
        instr    = rv_isa_pkg::NOP_WORD;        // no store strobe in reset
        pc_m     = '0;
        for (int i = 0; i < 32; i++)
            regs_m[i] = '0;
        for (int i = 0; i < 64; i++)
        begin
            dmem[i]  = 32'hc0de_0000 ^ (i * 32'h0101_0405);   // every address bit counts
            mem_m[i] = dmem[i];
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cur    = reset_store(0);
        instr <= encode(cur);
        for (int n = 0; n < N_TESTS; n++)
        begin
            @(negedge clk);                     // outputs settled mid cycle
            check_cycle(n);
            @(posedge clk);
            step_model();
            if (n + 1 < RESET_STORES)
                cur = reset_store(n + 1);
            else
                cur = gen_op();
            instr <= encode(cur);
        end
        if (i_dut.i_props.fail_cnt != 0)
            abort_run($sformatf("%0d bound assertion failures", i_dut.i_props.fail_cnt));
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // watchdog, sized from the test count
    initial
    begin
        #(TIMEOUT_NS);
        abort_run($sformatf("watchdog expired after %0d ns before the tests finished",
                            TIMEOUT_NS));
    end

endmodule

// File: dv/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props
(
    input logic              clk_i,
    input logic              rst_n_i,
    input rv_isa_pkg::word_t instr_i,
    input rv_isa_pkg::addr_t pc_i,        // core pc_o
    input logic              mem_we_i     // core mem_we_o
);

    int fail_cnt = 0;   // read by the testbench at the end

    // fetch stays word aligned
    pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pc_i[1:0] == 2'b00
    )
    else
    begin
        $error("pc_o is not word aligned");
        fail_cnt++;
    end

    // only stores may strobe the data port
    we_only_store: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (instr_i[rv_isa_pkg::OPC_W-1:0] != rv_isa_pkg::OP_STORE) |-> !mem_we_i
    )
    else
    begin
        $error("mem_we_o high for an instruction that is not a store");
        fail_cnt++;
    end

    pc_boot: assert property (
        @(posedge clk_i) $rose(rst_n_i) |-> pc_i == '0   // first cycle out of reset
    )
    else
    begin
        $error("pc_o not zero in the first cycle after reset");
        fail_cnt++;
    end

endmodule

bind rv_core rv_core_props i_props
(
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .instr_i  (instr_i),
    .pc_i     (pc_o),
    .mem_we_i (mem_we_o)
);

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  rv_isa_pkg::word_t instr_i,      // from instruction memory, same cycle
    output rv_isa_pkg::addr_t pc_o,
    output rv_isa_pkg::addr_t mem_addr_o,
    output rv_isa_pkg::word_t mem_wdata_o,
    output logic              mem_we_o,
    input  rv_isa_pkg::word_t mem_rdata_i
);

    rv_ctrl_pkg::ctrl_t   ctrl;
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::reg_idx_t rd_idx;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::word_t    rs1_data;
    rv_isa_pkg::word_t    rs2_data;
    rv_isa_pkg::word_t    alu_b;
    rv_isa_pkg::word_t    alu_result;
    logic                 alu_zero;
    rv_isa_pkg::addr_t    pc_plus4;
    rv_isa_pkg::word_t    wb_data;

    // register fields
    assign rs1_idx = instr_i[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_W];
    assign rs2_idx = instr_i[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_W];
    assign rd_idx  = instr_i[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_W];

    control_unit i_ctrl
    (
        .instr_i (instr_i),
        .zero_i  (alu_zero),
        .ctrl_o  (ctrl)
    );

    imm_extend i_imm
    (
        .instr_i   (instr_i),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    reg_file i_rf
    (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .rs1_i    (rs1_idx),
        .rs2_i    (rs2_idx),
        .rd_i     (rd_idx),
        .we_i     (ctrl.reg_write),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign alu_b = ctrl.alu_src ? imm : rs2_data;   // operand mux

    alu i_alu
    (
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .op_i     (ctrl.alu_op),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    pc_unit i_pc
    (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_src_i     (ctrl.pc_src),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .pc_o         (pc_o),
        .pc_plus4_o   (pc_plus4)
    );

    // write-back mux
    always_comb
    begin
        case (ctrl.result_src)
            rv_ctrl_pkg::RES_MEM: wb_data = mem_rdata_i;
            rv_ctrl_pkg::RES_PC4: wb_data = pc_plus4;     // jal / jalr link
            default:              wb_data = alu_result;
        endcase
    end

    // data port, address is base + offset from the alu
    assign mem_addr_o  = alu_result;
    assign mem_wdata_o = rs2_data;
    assign mem_we_o    = ctrl.mem_write;

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  rv_ctrl_pkg::pc_src_e pc_src_i,
    input  rv_isa_pkg::word_t    imm_i,          // branch or jal offset
    input  rv_isa_pkg::word_t    alu_result_i,   // jalr target
    output rv_isa_pkg::addr_t    pc_o,
    output rv_isa_pkg::addr_t    pc_plus4_o
);

    rv_isa_pkg::addr_t pc_q;
    rv_isa_pkg::addr_t pc_next;

    assign pc_plus4_o = pc_q + 32'd4;   // also the link value

    always_comb
    begin
        case (pc_src_i)
            rv_ctrl_pkg::PC_PLUS4: pc_next = pc_plus4_o;
            rv_ctrl_pkg::PC_REL:   pc_next = pc_q + imm_i;
            rv_ctrl_pkg::PC_ALU:   pc_next = {alu_result_i[31:1], 1'b0}; // clear lsb
            default:               pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pc_q <= '0;     // boot at address 0
        else
            pc_q <= pc_next;
    end

    assign pc_o = pc_q;

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  logic                 we_i,
    input  rv_isa_pkg::word_t    wdata_i,
    output rv_isa_pkg::word_t    rdata1_o,
    output rv_isa_pkg::word_t    rdata2_o
);

    rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];

    logic wr_en;

    assign wr_en = we_i && (rd_i != '0);  // x0 writes dropped

    // write at the edge that ends the cycle
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[rd_i] <= wdata_i;
        end
    end

    // async reads, x0 hardwired
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu
(
    input  rv_isa_pkg::word_t    a_i,       // rs1 data
    input  rv_isa_pkg::word_t    b_i,       // rs2 data or imm
    input  rv_ctrl_pkg::alu_op_e op_i,
    output rv_isa_pkg::word_t    result_o,
    output logic                 zero_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // only low five bits shift

    always_comb
    begin
        case (op_i)
            rv_ctrl_pkg::ALU_ADD: result_o = a_i + b_i;
            rv_ctrl_pkg::ALU_SUB: result_o = a_i - b_i;
            rv_ctrl_pkg::ALU_AND: result_o = a_i & b_i;
            rv_ctrl_pkg::ALU_OR:  result_o = a_i | b_i;
            rv_ctrl_pkg::ALU_XOR: result_o = a_i ^ b_i;
            rv_ctrl_pkg::ALU_SLL: result_o = a_i << shamt;
            default:              result_o = '0;
        endcase
    end

    // branch compare reads this after a sub
    assign zero_o = (result_o == '0);

endmodule

// File: logic/imm_extend.sv
`timescale 1ns/1ps

module imm_extend
(
    input  rv_isa_pkg::word_t     instr_i,
    input  rv_ctrl_pkg::imm_src_e imm_src_i,
    output rv_isa_pkg::word_t     imm_o
);

    logic sign;  // imm sign is always instr[31]

    assign sign = instr_i[31];

    always_comb
    begin
        case (imm_src_i)
            rv_ctrl_pkg::IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            rv_ctrl_pkg::IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            rv_ctrl_pkg::IMM_B:
            begin
                // 13 bit offset, lsb implied zero
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            rv_ctrl_pkg::IMM_J:
            begin
                // 21 bit offset, bits scrambled in the word
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: imm_o = {{20{sign}}, instr_i[31:20]};
        endcase
    end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
(
    input  rv_isa_pkg::word_t  instr_i,
    input  logic               zero_i,     // alu result was zero
    output rv_ctrl_pkg::ctrl_t ctrl_o
);

    rv_isa_pkg::opcode_e             opcode;
    logic [rv_isa_pkg::F3_W-1:0]     funct3;
    logic                            alt_bit;  // funct7[5]
    logic                            taken;

    // funct3 plus alt bit to alu op, unknown codes fall back to add
    function automatic rv_ctrl_pkg::alu_op_e alu_decode(
        input logic [rv_isa_pkg::F3_W-1:0] f3,
        input logic                        alt
    );
        rv_ctrl_pkg::alu_op_e op;
        case (rv_isa_pkg::funct3_alu_e'(f3))
            rv_isa_pkg::ADD_SUB: op = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::SLL:     op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::XOR:     op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::OR:      op = rv_ctrl_pkg::ALU_OR;
            rv_isa_pkg::AND:     op = rv_ctrl_pkg::ALU_AND;
            default:             op = rv_ctrl_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode  = rv_isa_pkg::opcode_e'(instr_i[rv_isa_pkg::OPC_W-1:0]);
    assign funct3  = instr_i[rv_isa_pkg::F3_LSB +: rv_isa_pkg::F3_W];
    assign alt_bit = instr_i[rv_isa_pkg::F7_ALT_BIT];

    // branch resolution, alu does rs1 - rs2 so zero means equal
    always_comb
    begin
        case (rv_isa_pkg::funct3_br_e'(funct3))
            rv_isa_pkg::BEQ: taken = zero_i;
            rv_isa_pkg::BNE: taken = ~zero_i;
            default:         taken = 1'b0;   // other branches not supported
        endcase
    end

    always_comb
    begin
        // no-op defaults, nothing written
        ctrl_o.reg_write  = 1'b0;
        ctrl_o.mem_write  = 1'b0;
        ctrl_o.alu_src    = 1'b0;
        ctrl_o.alu_op     = rv_ctrl_pkg::ALU_ADD;
        ctrl_o.imm_src    = rv_ctrl_pkg::IMM_I;
        ctrl_o.result_src = rv_ctrl_pkg::RES_ALU;
        ctrl_o.pc_src     = rv_ctrl_pkg::PC_PLUS4;

        case (opcode)
            rv_isa_pkg::OP_LOAD:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;                 // base + offset
                ctrl_o.result_src = rv_ctrl_pkg::RES_MEM;
            end
            rv_isa_pkg::OP_STORE:
            begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.imm_src   = rv_ctrl_pkg::IMM_S;    // split offset
            end
            rv_isa_pkg::OP_REG:
            begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = alu_decode(funct3, alt_bit);
            end
            rv_isa_pkg::OP_IMM:
            begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = alu_decode(funct3, 1'b0); // no subi
            end
            rv_isa_pkg::OP_BRANCH:
            begin
                ctrl_o.alu_op  = rv_ctrl_pkg::ALU_SUB;    // compare
                ctrl_o.imm_src = rv_ctrl_pkg::IMM_B;
                ctrl_o.pc_src  = taken ? rv_ctrl_pkg::PC_REL : rv_ctrl_pkg::PC_PLUS4;
            end
            rv_isa_pkg::OP_JAL:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.imm_src    = rv_ctrl_pkg::IMM_J;
                ctrl_o.result_src = rv_ctrl_pkg::RES_PC4; // link
                ctrl_o.pc_src     = rv_ctrl_pkg::PC_REL;
            end
            rv_isa_pkg::OP_JALR:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;                 // rs1 + imm is the target
                ctrl_o.result_src = rv_ctrl_pkg::RES_PC4;
                ctrl_o.pc_src     = rv_ctrl_pkg::PC_ALU;
            end
            default:
            begin
                // unknown opcode stays a no-op
            end
        endcase
    end

endmodule

// File: logic/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // alu operation, same codes as the older decoder
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLL = 3'b101
    } alu_op_e;

    // immediate layout
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_e;

    // write-back source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,    // load data
        RES_PC4 = 2'b10     // link address
    } result_src_e;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4 = 2'b00,
        PC_REL   = 2'b01,   // pc + imm, taken branch or jal
        PC_ALU   = 2'b10    // jalr target, bit 0 cleared
    } pc_src_e;

    // every datapath select for one instruction
    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        alu_src;     // b operand is imm, not rs2
        alu_op_e     alu_op;
        imm_src_e    imm_src;
        result_src_e result_src;
        pc_src_e     pc_src;
    } ctrl_t;

endpackage

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // widths
    localparam int XLEN     = 32;
    localparam int REG_W    = 5;    // register index bits
    localparam int NUM_REGS = 32;

    // instruction field positions
    localparam int OPC_W      = 7;  // opcode sits at [6:0]
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int F3_W       = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int F7_ALT_BIT = 30; // set for sub

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [XLEN-1:0]  addr_t;   // byte address
    typedef logic [REG_W-1:0] reg_idx_t;

    // major opcodes, base isa encodings
    typedef enum logic [OPC_W-1:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // funct3 for OP_REG and OP_IMM
    typedef enum logic [F3_W-1:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        XOR     = 3'b100,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_alu_e;

    typedef enum logic [F3_W-1:0] {
        BEQ = 3'b000,
        BNE = 3'b001
    } funct3_br_e;

    localparam word_t NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

endpackage
